/* vlog.f */
src/ppc_bus_pkg.sv
src/bus_request_ctrl.sv
src/address_tenure_ctrl.sv
src/data_tenure_ctrl.sv
src/snoop_response_ctrl.sv
src/ppc_bus_master.sv
verification/bus_master_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = bus_master_tb
FILELIST  = vlog.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/bus_master_tb.sv */
`timescale 1ns/10ps

module bus_master_tb;
   import ppc_bus_pkg::*;

   localparam int n_rows     = 10;
   localparam int wait_limit = 24;

   // one row is an own transfer or a foreign TS that the DUT has to snoop
   typedef struct packed {
      logic            own;
      xfer_attr_t      attr;
      logic            retry;
      snoop_resp_t     resp;
      logic [tt_w-1:0] exp_tt;
      logic            exp_tbst_n;
      logic            exp_gbl_n;
      logic [2:0]      exp_beats;
      logic            exp_artry_n;
      logic            exp_shd_n;
   } test_row_t;

   logic          clk;
   logic          arst_n;
   logic          core_req;
   xfer_attr_t    core_attr;
   snoop_resp_t   snoop_resp;
   addr_bus_in_t  addr_in;
   data_bus_in_t  data_in;
   addr_bus_out_t addr_out;
   logic          dbb_n;
   logic          artry_n;
   logic          shd_n;

   test_row_t rows [n_rows];
   string     names [n_rows];
   int        errors;
   int        row_errors;
   int        failed_tests;
   int        i;
   bit        aborted;

   ppc_bus_master dut_i (
      .clk, .arst_n, .core_req, .core_attr, .snoop_resp, .addr_in, .data_in,
      .addr_out, .dbb_n, .artry_n, .shd_n
   );

   always #5 clk = ~clk;

   // expected values follow the bus rules where burst types force TBST and broadcasts force GBL
   function automatic void fill_table();
      names[0] = "read_burst";
      rows[0]  = '{1'b1, '{xfer_read, 1'b1, 1'b1, 1'b0, 1'b0}, 1'b0, '{1'b0, 1'b0},
                   xfer_read, 1'b0, 1'b0, 3'd4, 1'b1, 1'b1};
      names[1] = "write_single";
      rows[1]  = '{1'b1, '{xfer_write_n_flush, 1'b0, 1'b0, 1'b1, 1'b1}, 1'b0, '{1'b0, 1'b0},
                   xfer_write_n_flush, 1'b1, 1'b1, 3'd1, 1'b1, 1'b1};
      names[2] = "rwitm_forced_burst";
      rows[2]  = '{1'b1, '{xfer_rwitm, 1'b0, 1'b1, 1'b0, 1'b0}, 1'b0, '{1'b0, 1'b0},
                   xfer_rwitm, 1'b0, 1'b0, 3'd4, 1'b1, 1'b1};
      names[3] = "sync_address_only";
      rows[3]  = '{1'b1, '{xfer_sync, 1'b0, 1'b0, 1'b0, 1'b0}, 1'b0, '{1'b0, 1'b0},
                   xfer_sync, 1'b1, 1'b0, 3'd0, 1'b1, 1'b1};
      names[4] = "read_retried";
      rows[4]  = '{1'b1, '{xfer_read, 1'b0, 1'b0, 1'b0, 1'b1}, 1'b1, '{1'b0, 1'b0},
                   xfer_read, 1'b1, 1'b1, 3'd0, 1'b1, 1'b1};
      names[5] = "kill_after_retry";
      rows[5]  = '{1'b1, '{xfer_write_n_kill, 1'b0, 1'b0, 1'b0, 1'b0}, 1'b0, '{1'b0, 1'b0},
                   xfer_write_n_kill, 1'b0, 1'b1, 3'd4, 1'b1, 1'b1};
      // in the snoop rows attr carries the foreign tt and gbl
      names[6] = "snoop_rwitm_shared";
      rows[6]  = '{1'b0, '{xfer_rwitm, 1'b0, 1'b1, 1'b0, 1'b0}, 1'b0, '{1'b0, 1'b1},
                   '0, 1'b1, 1'b1, 3'd0, 1'b0, 1'b0};
      names[7] = "snoop_read_shared";
      rows[7]  = '{1'b0, '{xfer_read, 1'b0, 1'b1, 1'b0, 1'b0}, 1'b0, '{1'b0, 1'b1},
                   '0, 1'b1, 1'b1, 3'd0, 1'b1, 1'b0};
      names[8] = "snoop_read_local";
      rows[8]  = '{1'b0, '{xfer_read, 1'b0, 1'b0, 1'b0, 1'b0}, 1'b0, '{1'b1, 1'b1},
                   '0, 1'b1, 1'b1, 3'd0, 1'b1, 1'b1};
      names[9] = "snoop_read_retry";
      rows[9]  = '{1'b0, '{xfer_read, 1'b0, 1'b1, 1'b0, 1'b0}, 1'b0, '{1'b1, 1'b0},
                   '0, 1'b1, 1'b1, 3'd0, 1'b0, 1'b1};
   endfunction

   task automatic check_equal(string name, string what, logic [7:0] exp, logic [7:0] act);
      assert (exp === act) else begin
         $display("[ERROR] %s: %s expected %0h, actual %0h", name, what, exp, act);
         row_errors++;
      end
   endtask

   task automatic report_failure(string name, string msg);
      $display("%s: %s", name, msg);
      row_errors++;
      aborted = 1'b1;
   endtask

   // attribute lines must match the captured request for as long as ABB is held
   task automatic check_attrs(int n, string phase);
      check_equal(names[n], {"tt in ", phase}, 8'(rows[n].exp_tt), 8'(addr_out.tt));
      check_equal(names[n], {"tbst_n in ", phase}, 8'(rows[n].exp_tbst_n), 8'(addr_out.tbst_n));
      check_equal(names[n], {"gbl_n in ", phase}, 8'(rows[n].exp_gbl_n), 8'(addr_out.gbl_n));
      check_equal(names[n], {"ci_n in ", phase}, 8'(!rows[n].attr.ci), 8'(addr_out.ci_n));
      check_equal(names[n], {"wt_n in ", phase}, 8'(!rows[n].attr.wt), 8'(addr_out.wt_n));
   endtask

   task automatic run_own(int n);
      test_row_t r;
      int        guard;
      int        beats;
      int        gap;
      r = rows[n];
      @(posedge clk);
      core_attr <= r.attr;
      core_req  <= 1'b1;
      guard = 0;
      @(negedge clk);
      while (addr_out.br_n && guard < wait_limit) begin
         @(negedge clk);
         guard++;
      end
      if (addr_out.br_n) begin
         report_failure(names[n], "BR was never asserted");
         return;
      end
      // once BR is out the request is latched and the arbiter answers 0 to 3 cycles later
      @(posedge clk);
      core_req <= 1'b0;
      repeat ($urandom % 4) @(posedge clk);
      addr_in.bg_n <= 1'b0;
      guard = 0;
      @(negedge clk);
      while (addr_out.ts_n && guard < wait_limit) begin
         @(negedge clk);
         guard++;
      end
      if (addr_out.ts_n) begin
         report_failure(names[n], "TS never followed the bus grant");
         return;
      end
      check_equal(names[n], "br_n in TS", 8'd1, 8'(addr_out.br_n));
      check_equal(names[n], "abb_n in TS", 8'd0, 8'(addr_out.abb_n));
      check_attrs(n, "TS");
      @(posedge clk);
      addr_in.bg_n <= 1'b1;
      @(negedge clk);
      check_equal(names[n], "ts_n after TS", 8'd1, 8'(addr_out.ts_n));
      check_equal(names[n], "abb_n before AACK", 8'd0, 8'(addr_out.abb_n));
      repeat ($urandom % 4) begin
         @(negedge clk);
         check_equal(names[n], "abb_n before AACK", 8'd0, 8'(addr_out.abb_n));
      end
      @(posedge clk);
      addr_in.aack_n <= 1'b0;
      @(negedge clk);
      check_equal(names[n], "abb_n in AACK", 8'd0, 8'(addr_out.abb_n));
      check_attrs(n, "AACK");
      // the window cycle follows AACK and a retry row pulls ARTRY here
      @(posedge clk);
      addr_in.aack_n  <= 1'b1;
      addr_in.artry_n <= !r.retry;
      @(negedge clk);
      check_equal(names[n], "abb_n in window", 8'd1, 8'(addr_out.abb_n));
      check_equal(names[n], "artry_n in window", 8'(r.exp_artry_n), 8'(artry_n));
      check_equal(names[n], "shd_n in window", 8'(r.exp_shd_n), 8'(shd_n));
      @(posedge clk);
      addr_in.artry_n <= 1'b1;
      repeat ($urandom % 4) @(posedge clk);
      data_in.dbg_n <= 1'b0;
      if (r.exp_beats == 0) begin
         // for an address-only or retried transfer DBG on its own must not open a data tenure
         repeat (6) begin
            @(negedge clk);
            check_equal(names[n], "dbb_n without data", 8'd1, 8'(dbb_n));
         end
         @(posedge clk);
         data_in.dbg_n <= 1'b1;
         return;
      end
      guard = 0;
      @(negedge clk);
      while (dbb_n && guard < wait_limit) begin
         @(negedge clk);
         guard++;
      end
      if (dbb_n) begin
         report_failure(names[n], "DBB was never asserted after the data bus grant");
         return;
      end
      // each beat waits 0 to 3 cycles before TA and only beats under DBB count
      beats = 0;
      guard = 0;
      gap   = $urandom % 4;
      while (!dbb_n && guard < wait_limit) begin
         @(posedge clk);
         data_in.dbg_n <= 1'b1;
         data_in.ta_n  <= (gap != 0);
         @(negedge clk);
         if (!data_in.ta_n && !dbb_n) begin
            beats++;
            gap = $urandom % 4;
         end else if (gap != 0) begin
            gap--;
         end
         guard++;
      end
      if (!dbb_n) begin
         report_failure(names[n], "the data tenure did not end");
         return;
      end
      @(posedge clk);
      data_in.ta_n <= 1'b1;
      check_equal(names[n], "TA beats", 8'(r.exp_beats), 8'(beats));
   endtask

   task automatic run_snoop(int n);
      test_row_t r;
      int        late;
      int        k;
      logic      in_window;
      r = rows[n];
      @(posedge clk);
      snoop_resp    <= r.resp;
      addr_in.ts_n  <= 1'b0;
      addr_in.abb_n <= 1'b0;
      addr_in.tt    <= r.attr.tt;
      addr_in.gbl_n <= !r.attr.gbl;
      // cycle k counts from the TS cycle and AACK comes in cycle 3 at the earliest
      late = $urandom % 4;
      for (k = 1; k <= late + 5; k++) begin
         @(posedge clk);
         addr_in.ts_n   <= 1'b1;
         addr_in.aack_n <= (k != late + 3);
         if (k == late + 4) begin
            addr_in.abb_n <= 1'b1;
            addr_in.tt    <= '1;
            addr_in.gbl_n <= 1'b1;
         end
         @(negedge clk);
         // response from the fourth cycle up to one cycle past the delayed AACK
         in_window = (k >= 4) && (k <= late + 4);
         check_equal(names[n], $sformatf("artry_n in cycle %0d", k),
                     8'(in_window ? r.exp_artry_n : 1'b1), 8'(artry_n));
         check_equal(names[n], $sformatf("shd_n in cycle %0d", k),
                     8'(in_window ? r.exp_shd_n : 1'b1), 8'(shd_n));
      end
      @(posedge clk);
      snoop_resp <= '0;
   endtask

   initial begin
      void'($urandom(5));
      clk          = 1'b0;
      errors       = 0;
      failed_tests = 0;
      aborted      = 1'b0;
      arst_n     <= 1'b0;
      core_req   <= 1'b0;
      core_attr  <= '0;
      snoop_resp <= '0;
      addr_in    <= '1;
      data_in    <= '1;
      fill_table();
      repeat (2) @(posedge clk);
      arst_n <= 1'b1;
      i = 0;
      while (i < n_rows && !aborted) begin
         repeat (2) @(posedge clk);
         row_errors = 0;
         if (rows[i].own) begin
            run_own(i);
         end else begin
            run_snoop(i);
         end
         if (row_errors == 0) begin
            $display("%s: passed", names[i]);
         end else begin
            $display("%s: failed with %0d errors", names[i], row_errors);
            failed_tests++;
         end
         errors += row_errors;
         i++;
      end
      $display("tests run %0d, tests failed %0d, checks failed %0d", i, failed_tests, errors);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

/* src/ppc_bus_master.sv */
`timescale 1ns/10ps

module ppc_bus_master (
   input  logic                       clk,
   input  logic                       arst_n,
   input  logic                       core_req,
   input  ppc_bus_pkg::xfer_attr_t    core_attr,
   input  ppc_bus_pkg::snoop_resp_t   snoop_resp,
   input  ppc_bus_pkg::addr_bus_in_t  addr_in,
   input  ppc_bus_pkg::data_bus_in_t  data_in,
   output ppc_bus_pkg::addr_bus_out_t addr_out,
   output logic                       dbb_n,
   output logic                       artry_n,
   output logic                       shd_n
);
   import ppc_bus_pkg::*;

   logic            qual_grant;
   logic            req_active;
   logic            tenure_busy;
   logic            last_master;
   addr_state_t     addr_state;
   xfer_attr_t      attr;
   logic            br_n;
   logic            ts_n;
   logic            abb_n;
   logic            tbst_n;
   logic            gbl_n;
   logic            ci_n;
   logic            wt_n;
   logic [tt_w-1:0] tt;

   // arbitration side, requests the bus and qualifies BG
   bus_request_ctrl req_i (
      .clk, .arst_n, .core_req, .addr_in, .addr_state, .tenure_busy,
      .qual_grant, .req_active, .br_n
   );

   // address tenure, owns TS, ABB and the attribute lines
   address_tenure_ctrl addr_i (
      .clk, .arst_n, .addr_in, .core_attr, .qual_grant, .req_active, .tenure_busy,
      .addr_state, .last_master, .attr, .ts_n, .abb_n, .tbst_n, .gbl_n, .ci_n, .wt_n, .tt
   );

   // data tenure that belongs to the last address tenure of this master
   data_tenure_ctrl data_i (
      .clk, .arst_n, .addr_in, .data_in, .addr_state, .last_master, .attr,
      .tenure_busy, .dbb_n
   );

   // snoop responder for every TS seen on the bus
   snoop_response_ctrl snoop_i (
      .clk, .arst_n, .addr_in, .addr_state, .snoop_resp, .artry_n, .shd_n
   );

   assign addr_out = '{br_n: br_n, ts_n: ts_n, abb_n: abb_n, tt: tt, tbst_n: tbst_n,
                       gbl_n: gbl_n, ci_n: ci_n, wt_n: wt_n};

endmodule

/* src/snoop_response_ctrl.sv */
`timescale 1ns/10ps

module snoop_response_ctrl (
   input  logic                      clk,
   input  logic                      arst_n,
   input  ppc_bus_pkg::addr_bus_in_t addr_in,
   input  ppc_bus_pkg::addr_state_t  addr_state,
   input  ppc_bus_pkg::snoop_resp_t  snoop_resp,
   output logic                      artry_n,
   output logic                      shd_n
);
   import ppc_bus_pkg::*;

   snoop_state_t state;
   logic         aack_d_n;
   logic         own;
   logic         gbl;
   logic         want_retry;
   logic         want_shared;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         aack_d_n <= 1'b1;
      end else begin
         aack_d_n <= addr_in.aack_n;
      end
   end

   // snooping our own tenure is legal for a few broadcast types only
   assign own = (addr_state == addr_ts) || (addr_state == addr_aack_wait);
   assign gbl = !addr_in.gbl_n;

   // the cache's wish is cut down to what the transfer type permits
   assign want_shared = snoop_resp.shared && shared_allowed(addr_in.tt, gbl, own);
   assign want_retry  = (snoop_resp.retry && artry_allowed(addr_in.tt, gbl, own))
                        || (want_shared && shared_implies_artry(addr_in.tt));

   // the response window opens no earlier than four cycles after TS and
   // the lines are released the cycle after the delayed AACK
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= snoop_idle;
      end else if (!addr_in.ts_n) begin
         state <= snoop_ts_1;
      end else if (!aack_d_n) begin
         state <= snoop_idle;
      end else begin
         case (state)
            snoop_ts_1:  state <= snoop_ts_2;
            snoop_ts_2:  state <= snoop_ready;
            snoop_ready:
               // with nothing to say we keep sampling until AACK closes it
               if (want_retry && want_shared) begin
                  state <= snoop_both;
               end else if (want_retry) begin
                  state <= snoop_artry;
               end else if (want_shared) begin
                  state <= snoop_shared;
               end
            default:     state <= state;
         endcase
      end
   end

   assign artry_n = !(state == snoop_artry || state == snoop_both);
   assign shd_n   = !(state == snoop_shared || state == snoop_both);

endmodule

/* src/data_tenure_ctrl.sv */
`timescale 1ns/10ps

module data_tenure_ctrl (
   input  logic                      clk,
   input  logic                      arst_n,
   input  ppc_bus_pkg::addr_bus_in_t addr_in,
   input  ppc_bus_pkg::data_bus_in_t data_in,
   input  ppc_bus_pkg::addr_state_t  addr_state,
   input  logic                      last_master,
   input  ppc_bus_pkg::xfer_attr_t   attr,
   output logic                      tenure_busy,
   output logic                      dbb_n
);
   import ppc_bus_pkg::*;

   data_state_t state;
   beat_cnt_t   beat_cnt;
   logic        pending_q;
   logic        pending;
   logic        addr_only;
   logic        burst;
   logic        own_retry;
   logic        start;
   logic        last_beat;

   assign addr_only = !(is_read(attr.tt) || is_write(attr.tt));

   // same burst rule as TBST on the address bus
   assign burst = attr.burst || tbst_never(attr.tt);

   // a retry of our own address tenure throws away its data tenure too
   assign own_retry = !addr_in.artry_n && last_master;

   // the registered flag lags TS by a cycle, so the TS cycle is covered here
   assign pending = pending_q || (addr_state == addr_ts && !addr_only);

   // qualified data bus grant, DBG with nobody else holding DBB
   assign start = !data_in.dbg_n && data_in.dbb_n && pending && state == data_idle;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pending_q <= 1'b0;
      end else if (own_retry || start) begin
         pending_q <= 1'b0;
      end else if (addr_state == addr_ts) begin
         pending_q <= !addr_only;
      end
   end

   assign last_beat = !burst || (beat_cnt == beat_cnt_t'(burst_beats - 1));

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state    <= data_idle;
         beat_cnt <= '0;
      end else if (own_retry) begin
         state <= data_idle;
      end else begin
         case (state)
            data_idle:
               if (start) begin
                  state    <= data_ta_wait;
                  beat_cnt <= '0;
               end
            default:
               // every TA is one beat, the tenure ends on the final one
               if (!data_in.ta_n) begin
                  if (last_beat) begin
                     state <= data_idle;
                  end else begin
                     beat_cnt <= beat_cnt + 1'b1;
                  end
               end
         endcase
      end
   end

   assign tenure_busy = pending || (state != data_idle);
   assign dbb_n       = (state != data_ta_wait);

endmodule

/* src/address_tenure_ctrl.sv */
`timescale 1ns/10ps

module address_tenure_ctrl (
   input  logic                             clk,
   input  logic                             arst_n,
   input  ppc_bus_pkg::addr_bus_in_t        addr_in,
   input  ppc_bus_pkg::xfer_attr_t          core_attr,
   input  logic                             qual_grant,
   input  logic                             req_active,
   input  logic                             tenure_busy,
   output ppc_bus_pkg::addr_state_t         addr_state,
   output logic                             last_master,
   output ppc_bus_pkg::xfer_attr_t          attr,
   output logic                             ts_n,
   output logic                             abb_n,
   output logic                             tbst_n,
   output logic                             gbl_n,
   output logic                             ci_n,
   output logic                             wt_n,
   output logic [ppc_bus_pkg::tt_w-1:0]     tt
);
   import ppc_bus_pkg::*;

   addr_state_t next_state;
   logic        start_ts;
   logic        own_bus;

   // a grant is only usable when our previous data tenure is fully done
   assign start_ts = req_active && qual_grant && !tenure_busy;

   always_comb begin
      next_state = addr_state;
      case (addr_state)
         addr_idle:
            if (start_ts) begin
               next_state = addr_ts;
            end
         addr_ts:
            next_state = addr_aack_wait;
         // the target may hold off AACK for as long as it needs
         addr_aack_wait:
            if (!addr_in.aack_n) begin
               next_state = addr_awindow;
            end
         // in the ARTRY window a parked master can start again straight from here
         addr_awindow:
            if (!addr_in.artry_n) begin
               next_state = addr_artry_hold;
            end else if (start_ts) begin
               next_state = addr_ts;
            end else begin
               next_state = addr_idle;
            end
         default:
            next_state = addr_idle;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         addr_state <= addr_idle;
      end else begin
         addr_state <= next_state;
      end
   end

   // the core keeps its attributes stable until it sees TS, so grab them on entry
   always_ff @(posedge clk) begin
      if (next_state == addr_ts) begin
         attr <= core_attr;
      end
   end

   // the last TS on the bus decides which data tenure an ARTRY kills
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         last_master <= 1'b0;
      end else if (addr_state == addr_ts) begin
         last_master <= 1'b1;
      end else if (!addr_in.ts_n) begin
         last_master <= 1'b0;
      end
   end

   // we own the address bus from TS up to and including the AACK cycle
   assign own_bus = (addr_state == addr_ts) || (addr_state == addr_aack_wait);

   assign ts_n   = !(addr_state == addr_ts);
   assign abb_n  = !own_bus;
   assign tt     = own_bus ? attr.tt : '1;
   assign tbst_n = !(own_bus && (attr.burst || tbst_never(attr.tt)));
   assign gbl_n  = !(own_bus && (attr.gbl || gbl_forced(attr.tt)));
   assign ci_n   = !(own_bus && attr.ci);
   assign wt_n   = !(own_bus && attr.wt);

endmodule

/* src/bus_request_ctrl.sv */
`timescale 1ns/10ps

module bus_request_ctrl (
   input  logic                      clk,
   input  logic                      arst_n,
   input  logic                      core_req,
   input  ppc_bus_pkg::addr_bus_in_t addr_in,
   input  ppc_bus_pkg::addr_state_t  addr_state,
   input  logic                      tenure_busy,
   output logic                      qual_grant,
   output logic                      req_active,
   output logic                      br_n
);
   import ppc_bus_pkg::*;

   bus_req_state_t state;
   logic           artry_d_n;

   // ARTRY of the previous cycle also blocks the grant, so a retried
   // master gets one clear cycle before anybody restarts
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         artry_d_n <= 1'b1;
      end else begin
         artry_d_n <= addr_in.artry_n;
      end
   end

   // BG only counts when no retry is in flight and the address bus is free
   assign qual_grant = !addr_in.bg_n && addr_in.artry_n && artry_d_n && addr_in.abb_n;

   // no new request while our own data tenure is still open, since only
   // one transfer of this master is tracked at a time
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= req_idle;
      end else begin
         case (state)
            req_idle:
               if (core_req && !tenure_busy && addr_in.artry_n) begin
                  state <= req_normal;
               end
            default:
               if (qual_grant || !addr_in.artry_n) begin
                  state <= req_idle;
               end
         endcase
      end
   end

   assign req_active = (state == req_normal);

   // BR drops right away in the TS cycle and stays off during the retry hold
   assign br_n = !(req_active && addr_state != addr_ts && addr_state != addr_artry_hold);

endmodule

/* src/ppc_bus_pkg.sv */
package ppc_bus_pkg;

   localparam int tt_w = 5;

   // transfer type codes as they appear on TT[0:4] of the 60x bus
   localparam logic [tt_w-1:0] xfer_clean_block          = 5'b00000;
   localparam logic [tt_w-1:0] xfer_flush_block          = 5'b00100;
   localparam logic [tt_w-1:0] xfer_sync                 = 5'b01000;
   localparam logic [tt_w-1:0] xfer_kill_block           = 5'b01100;
   localparam logic [tt_w-1:0] xfer_eieio                = 5'b10000;
   localparam logic [tt_w-1:0] xfer_tlbie                = 5'b11000;
   localparam logic [tt_w-1:0] xfer_tlbsync              = 5'b01001;
   localparam logic [tt_w-1:0] xfer_icbi                 = 5'b01101;
   localparam logic [tt_w-1:0] xfer_read                 = 5'b01010;
   localparam logic [tt_w-1:0] xfer_read_atomic          = 5'b11010;
   localparam logic [tt_w-1:0] xfer_rwitm                = 5'b01110;
   localparam logic [tt_w-1:0] xfer_rwitm_atomic         = 5'b11110;
   localparam logic [tt_w-1:0] xfer_write_n_flush        = 5'b00010;
   localparam logic [tt_w-1:0] xfer_write_n_flush_atomic = 5'b10010;
   localparam logic [tt_w-1:0] xfer_write_n_kill         = 5'b00110;

   // a burst moves one cache line in this many TA beats
   localparam int burst_beats = 4;

   typedef logic [1:0] beat_cnt_t;

   typedef enum logic {req_idle, req_normal} bus_req_state_t;

   typedef enum logic [2:0] {
      addr_idle, addr_ts, addr_aack_wait, addr_awindow, addr_artry_hold
   } addr_state_t;

   typedef enum logic {data_idle, data_ta_wait} data_state_t;

   typedef enum logic [2:0] {
      snoop_idle, snoop_ts_1, snoop_ts_2, snoop_ready, snoop_artry, snoop_shared, snoop_both
   } snoop_state_t;

   // request attributes from the core, all active high
   typedef struct packed {
      logic [tt_w-1:0] tt;
      logic            burst;
      logic            gbl;
      logic            ci;
      logic            wt;
   } xfer_attr_t;

   // what the local cache would like to answer to a snooped address
   typedef struct packed {
      logic retry;
      logic shared;
   } snoop_resp_t;

   // address bus as seen by this master, after the wired-OR with all other agents
   typedef struct packed {
      logic            bg_n;
      logic            abb_n;
      logic            ts_n;
      logic [tt_w-1:0] tt;
      logic            gbl_n;
      logic            aack_n;
      logic            artry_n;
   } addr_bus_in_t;

   typedef struct packed {
      logic dbg_n;
      logic dbb_n;
      logic ta_n;
   } data_bus_in_t;

   typedef struct packed {
      logic            br_n;
      logic            ts_n;
      logic            abb_n;
      logic [tt_w-1:0] tt;
      logic            tbst_n;
      logic            gbl_n;
      logic            ci_n;
      logic            wt_n;
   } addr_bus_out_t;

   function automatic logic is_read(logic [tt_w-1:0] tt);
      return tt inside {xfer_read, xfer_read_atomic, xfer_rwitm, xfer_rwitm_atomic};
   endfunction

   function automatic logic is_write(logic [tt_w-1:0] tt);
      return tt inside {xfer_write_n_flush, xfer_write_n_flush_atomic, xfer_write_n_kill};
   endfunction

   // these types always move a full line, so TBST is never left negated
   function automatic logic tbst_never(logic [tt_w-1:0] tt);
      return tt inside {xfer_rwitm, xfer_rwitm_atomic, xfer_write_n_kill};
   endfunction

   // broadcast operations must be seen by every snooper, so GBL is forced on
   function automatic logic gbl_forced(logic [tt_w-1:0] tt);
      return tt inside {xfer_sync, xfer_tlbsync, xfer_tlbie, xfer_eieio};
   endfunction

   // a master may only retry its own tenure for the broadcast cache and TLB ops
   function automatic logic artry_allowed(logic [tt_w-1:0] tt, logic gbl, logic own);
      return (gbl && !own && tt inside {xfer_clean_block, xfer_flush_block, xfer_kill_block,
                                        xfer_write_n_flush, xfer_write_n_flush_atomic,
                                        xfer_write_n_kill, xfer_read, xfer_read_atomic,
                                        xfer_rwitm, xfer_rwitm_atomic, xfer_tlbie,
                                        xfer_tlbsync, xfer_sync, xfer_icbi})
             || (own && tt inside {xfer_tlbie, xfer_tlbsync, xfer_sync, xfer_icbi});
   endfunction

   function automatic logic shared_allowed(logic [tt_w-1:0] tt, logic gbl, logic own);
      return (gbl && !own && tt inside {xfer_clean_block, xfer_flush_block, xfer_write_n_flush,
                                        xfer_write_n_flush_atomic, xfer_read, xfer_read_atomic,
                                        xfer_rwitm, xfer_rwitm_atomic, xfer_icbi})
             || (own && tt == xfer_icbi);
   endfunction

   // for these SHD only ever travels together with ARTRY and signals a push
   function automatic logic shared_implies_artry(logic [tt_w-1:0] tt);
      return tt inside {xfer_clean_block, xfer_flush_block, xfer_write_n_flush,
                        xfer_write_n_flush_atomic, xfer_rwitm, xfer_rwitm_atomic, xfer_icbi};
   endfunction

endpackage
